/* verilog/mem_geom_pkg.sv */
package mem_geom_pkg;

  localparam int WIDTH = 16;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;
  localparam int BITADDR = 6;

  // physical addresses carry one more bank bit so the cache can be named.
  localparam int BITPBNK = 3;
  localparam int BITPADR = 7;
  localparam logic [BITPBNK-1:0] CACHE_BANK = 3'd4;

  // a logical address is seen either as one flat word or as row and bank.
  typedef union packed {
    logic [BITADDR-1:0] flat;
    struct packed {
      logic [BITVROW-1:0] row;
      logic [BITVBNK-1:0] bank;
    } f;
  } mem_addr_u;

endpackage

/* verilog/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;
  import mem_geom_pkg::*;

  localparam logic [1:0] ST_RESET = 2'd0;
  localparam logic [1:0] ST_INIT = 2'd1;
  localparam logic [1:0] ST_READY = 2'd2;

  // the sweep clears one row of every bank per cycle.
  localparam logic [BITVROW-1:0] SWEEP_LAST = BITVROW'(NUMVROW - 1);

endpackage

/* verilog/bank_wr_if.sv */
`timescale 1ns/1ns

interface bank_wr_if import mem_geom_pkg::*; ();

  logic               write;
  logic [BITVBNK-1:0] bank;
  logic [BITVROW-1:0] row;
  logic [WIDTH-1:0]   data;

  modport src (output write, output bank, output row, output data);
  modport dst (input write, input bank, input row, input data);

endinterface

/* verilog/init_fsm.sv */
`timescale 1ns/1ns

module init_fsm import mem_ctrl_pkg::*; (
  input  logic clk,
  input  logic rstvld,
  input  logic sweep_last,
  output logic sweep_en,
  output logic ready
);

  logic [1:0] state;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state <= ST_RESET;
    end else begin
      case (state)
        ST_RESET: state <= ST_INIT;
        ST_INIT: begin
          if (sweep_last) begin
            state <= ST_READY;
          end
        end
        ST_READY: state <= ST_READY;
        // the spare code falls back to a fresh start.
        default: state <= ST_RESET;
      endcase
    end
  end

  assign sweep_en = (state == ST_INIT);
  assign ready = (state == ST_READY);

endmodule

/* verilog/row_sweep_counter.sv */
`timescale 1ns/1ns

module row_sweep_counter import mem_geom_pkg::*, mem_ctrl_pkg::*; (
  input  logic               clk,
  input  logic               rstvld,
  input  logic               sweep_en,
  output logic [BITVROW-1:0] sweep_row,
  output logic               sweep_last
);

  // the row wraps back to zero after the last one, ready for the next sweep.
  always_ff @(posedge clk) begin
    if (rstvld) begin
      sweep_row <= '0;
    end else if (sweep_en) begin
      sweep_row <= sweep_row + 1'b1;
    end
  end

  assign sweep_last = sweep_en && (sweep_row == SWEEP_LAST);

endmodule

/* verilog/write_router.sv */
`timescale 1ns/1ns

module write_router import mem_geom_pkg::*; (
  input  logic               ready,
  input  logic               wr_a,
  input  logic               wr_b,
  input  mem_addr_u          wr_a_addr,
  input  mem_addr_u          wr_b_addr,
  input  logic [WIDTH-1:0]   wr_a_data,
  input  logic [WIDTH-1:0]   wr_b_data,
  input  logic               map_a_valid,
  input  logic [BITVBNK-1:0] map_a_bank,
  input  logic               map_b_valid,
  input  logic [BITVBNK-1:0] map_b_bank,
  input  logic [WIDTH-1:0]   cache_b_data,
  bank_wr_if.src             pvt_a,
  bank_wr_if.src             pvt_b,
  output logic               cache_write,
  output logic [BITVROW-1:0] cache_row,
  output logic [WIDTH-1:0]   cache_data,
  output logic               map_write,
  output logic [BITVROW-1:0] map_row,
  output logic               map_valid,
  output logic [BITVBNK-1:0] map_bank
);

  logic wr_a_ok;
  logic wr_b_ok;
  logic a_hit;
  logic b_hit;
  logic b_to_cache;
  logic evict;

  // port B wins when both ports name the same address.
  assign wr_b_ok = wr_b && ready;
  assign wr_a_ok = wr_a && ready && !(wr_b_ok && (wr_a_addr.flat == wr_b_addr.flat));

  assign a_hit = wr_a_ok && map_a_valid && (map_a_bank == wr_a_addr.f.bank);
  assign b_hit = wr_b_ok && map_b_valid && (map_b_bank == wr_b_addr.f.bank);

  // a bank conflict sends B into the cache, unless A already took it.
  assign b_to_cache = wr_a_ok && wr_b_ok && !a_hit &&
                      (wr_a_addr.f.bank == wr_b_addr.f.bank);
  assign evict = b_to_cache && map_b_valid && (map_b_bank != wr_b_addr.f.bank);

  assign cache_write = a_hit || b_to_cache;
  assign cache_row = a_hit ? wr_a_addr.f.row : wr_b_addr.f.row;
  assign cache_data = a_hit ? wr_a_data : wr_b_data;

  // the map entry follows B; a pivot write of B retires a stale cache copy.
  assign map_write = b_to_cache || b_hit;
  assign map_row = wr_b_addr.f.row;
  assign map_valid = b_to_cache;
  assign map_bank = wr_b_addr.f.bank;

  assign pvt_a.write = wr_a_ok && !a_hit;
  assign pvt_a.bank = wr_a_addr.f.bank;
  assign pvt_a.row = wr_a_addr.f.row;
  assign pvt_a.data = wr_a_data;

  // channel b carries either B itself or the evicted cache word.
  assign pvt_b.write = b_to_cache ? evict : wr_b_ok;
  assign pvt_b.bank = b_to_cache ? map_b_bank : wr_b_addr.f.bank;
  assign pvt_b.row = wr_b_addr.f.row;
  assign pvt_b.data = b_to_cache ? cache_b_data : wr_b_data;

endmodule

/* verilog/pivot_banks.sv */
`timescale 1ns/1ns

module pivot_banks import mem_geom_pkg::*; (
  input  logic               clk,
  input  logic               sweep_en,
  input  logic [BITVROW-1:0] sweep_row,
  bank_wr_if.dst             pvt_a,
  bank_wr_if.dst             pvt_b,
  input  mem_addr_u          rd_addr,
  output logic [WIDTH-1:0]   pvt_rd_data
);

  logic [WIDTH-1:0] bank_q [NUMVBNK];

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    logic [WIDTH-1:0] mem [NUMVROW];
    logic             sel_a;
    logic             sel_b;

    assign sel_a = pvt_a.write && (pvt_a.bank == BITVBNK'(b));
    assign sel_b = pvt_b.write && (pvt_b.bank == BITVBNK'(b));

    // the router never aims both channels at one bank.
    always_ff @(posedge clk) begin
      if (sweep_en) begin
        mem[sweep_row] <= '0;
      end else if (sel_b) begin
        mem[pvt_b.row] <= pvt_b.data;
      end else if (sel_a) begin
        mem[pvt_a.row] <= pvt_a.data;
      end
    end

    assign bank_q[b] = mem[rd_addr.f.row];
  end

  always_ff @(posedge clk) begin
    pvt_rd_data <= bank_q[rd_addr.f.bank];
  end

endmodule

/* verilog/spare_bank.sv */
`timescale 1ns/1ns

module spare_bank import mem_geom_pkg::*; (
  input  logic               clk,
  input  logic               sweep_en,
  input  logic [BITVROW-1:0] sweep_row,
  input  logic               cache_write,
  input  logic [BITVROW-1:0] cache_row,
  input  logic [WIDTH-1:0]   cache_data,
  input  logic               map_write,
  input  logic [BITVROW-1:0] map_row,
  input  logic               map_valid,
  input  logic [BITVBNK-1:0] map_bank,
  input  logic [BITVROW-1:0] wr_a_row,
  input  logic [BITVROW-1:0] wr_b_row,
  output logic               map_a_valid,
  output logic [BITVBNK-1:0] map_a_bank,
  output logic               map_b_valid,
  output logic [BITVBNK-1:0] map_b_bank,
  output logic [WIDTH-1:0]   cache_b_data,
  input  logic [BITVROW-1:0] rd_row,
  output logic [WIDTH-1:0]   cache_rd_data,
  output logic               rd_map_valid,
  output logic [BITVBNK-1:0] rd_map_bank
);

  logic [WIDTH-1:0]   cache [NUMVROW];
  logic               map_vld [NUMVROW];
  logic [BITVBNK-1:0] map_bnk [NUMVROW];

  always_ff @(posedge clk) begin
    if (sweep_en) begin
      cache[sweep_row] <= '0;
      map_vld[sweep_row] <= 1'b0;
      map_bnk[sweep_row] <= '0;
    end else begin
      if (cache_write) begin
        cache[cache_row] <= cache_data;
      end
      if (map_write) begin
        map_vld[map_row] <= map_valid;
        map_bnk[map_row] <= map_bank;
      end
    end
  end

  // the router sees the entries as they stand before this cycle's writes.
  assign map_a_valid = map_vld[wr_a_row];
  assign map_a_bank = map_bnk[wr_a_row];
  assign map_b_valid = map_vld[wr_b_row];
  assign map_b_bank = map_bnk[wr_b_row];
  assign cache_b_data = cache[wr_b_row];

  always_ff @(posedge clk) begin
    cache_rd_data <= cache[rd_row];
    rd_map_valid <= map_vld[rd_row];
    rd_map_bank <= map_bnk[rd_row];
  end

endmodule

/* verilog/read_select.sv */
`timescale 1ns/1ns

module read_select import mem_geom_pkg::*; (
  input  logic               clk,
  input  logic               rstvld,
  input  logic               ready,
  input  logic               rd,
  input  mem_addr_u          rd_addr,
  input  logic [WIDTH-1:0]   pvt_rd_data,
  input  logic [WIDTH-1:0]   cache_rd_data,
  input  logic               rd_map_valid,
  input  logic [BITVBNK-1:0] rd_map_bank,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_data,
  output logic [BITPADR-1:0] rd_padr
);

  mem_addr_u rd_addr_q;
  logic      rd_hit;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd && ready;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rd_addr_q <= rd_addr;
    end
  end

  // the map and both arrays were sampled on the same edge as the address.
  assign rd_hit = rd_map_valid && (rd_map_bank == rd_addr_q.f.bank);

  assign rd_data = rd_hit ? cache_rd_data : pvt_rd_data;
  assign rd_padr = rd_hit ? {CACHE_BANK, rd_addr_q.f.row} :
                            {BITPBNK'(rd_addr_q.f.bank), rd_addr_q.f.row};

endmodule

/* verilog/dual_write_mem.sv */
`timescale 1ns/1ns

module dual_write_mem import mem_geom_pkg::*; (
  input  logic               clk,
  input  logic               rstvld,
  output logic               ready,
  input  logic               wr_a,
  input  logic [BITADDR-1:0] wr_a_addr,
  input  logic [WIDTH-1:0]   wr_a_data,
  input  logic               wr_b,
  input  logic [BITADDR-1:0] wr_b_addr,
  input  logic [WIDTH-1:0]   wr_b_data,
  input  logic               rd,
  input  logic [BITADDR-1:0] rd_addr,
  output logic               rd_vld,
  output logic [WIDTH-1:0]   rd_data,
  output logic [BITPADR-1:0] rd_padr
);

  wire mem_addr_u wr_a_adr = wr_a_addr;
  wire mem_addr_u wr_b_adr = wr_b_addr;
  wire mem_addr_u rd_adr = rd_addr;

  wire               sweep_en;
  wire               sweep_last;
  wire [BITVROW-1:0] sweep_row;

  wire               map_a_valid;
  wire [BITVBNK-1:0] map_a_bank;
  wire               map_b_valid;
  wire [BITVBNK-1:0] map_b_bank;
  wire [WIDTH-1:0]   cache_b_data;

  wire               cache_write;
  wire [BITVROW-1:0] cache_row;
  wire [WIDTH-1:0]   cache_data;
  wire               map_write;
  wire [BITVROW-1:0] map_row;
  wire               map_valid;
  wire [BITVBNK-1:0] map_bank;

  wire [WIDTH-1:0]   pvt_rd_data;
  wire [WIDTH-1:0]   cache_rd_data;
  wire               rd_map_valid;
  wire [BITVBNK-1:0] rd_map_bank;

  bank_wr_if pvt_a ();
  bank_wr_if pvt_b ();

  init_fsm init_fsm_i (
    .clk, .rstvld, .sweep_last, .sweep_en, .ready
  );

  row_sweep_counter row_sweep_counter_i (
    .clk, .rstvld, .sweep_en, .sweep_row, .sweep_last
  );

  write_router write_router_i (
    .ready, .wr_a, .wr_b, .wr_a_addr(wr_a_adr), .wr_b_addr(wr_b_adr),
    .wr_a_data, .wr_b_data, .map_a_valid, .map_a_bank, .map_b_valid,
    .map_b_bank, .cache_b_data, .pvt_a(pvt_a.src), .pvt_b(pvt_b.src),
    .cache_write, .cache_row, .cache_data,
    .map_write, .map_row, .map_valid, .map_bank
  );

  pivot_banks pivot_banks_i (
    .clk, .sweep_en, .sweep_row, .pvt_a(pvt_a.dst), .pvt_b(pvt_b.dst),
    .rd_addr(rd_adr), .pvt_rd_data
  );

  spare_bank spare_bank_i (
    .clk, .sweep_en, .sweep_row, .cache_write, .cache_row, .cache_data,
    .map_write, .map_row, .map_valid, .map_bank,
    .wr_a_row(wr_a_adr.f.row), .wr_b_row(wr_b_adr.f.row),
    .map_a_valid, .map_a_bank, .map_b_valid, .map_b_bank, .cache_b_data,
    .rd_row(rd_adr.f.row), .cache_rd_data, .rd_map_valid, .rd_map_bank
  );

  read_select read_select_i (
    .clk, .rstvld, .ready, .rd, .rd_addr(rd_adr), .pvt_rd_data,
    .cache_rd_data, .rd_map_valid, .rd_map_bank, .rd_vld, .rd_data, .rd_padr
  );

endmodule

/* sim/dual_write_mem_assertions.sv */
`timescale 1ns/1ns

module dual_write_mem_assertions import mem_geom_pkg::*; (
  input logic               clk,
  input logic               rstvld,
  input logic               ready,
  input logic               rd_vld,
  input logic               a_write,
  input logic [BITVBNK-1:0] a_bank,
  input logic               b_write,
  input logic [BITVBNK-1:0] b_bank,
  input logic               cache_write,
  input logic               map_write
);

  // each pivot bank has a single write port.
  no_bank_clash: assert property (@(posedge clk) disable iff (rstvld)
    (a_write && b_write) |-> (a_bank != b_bank))
    else $error("channels a and b write the same pivot bank");

  no_read_before_ready: assert property (@(posedge clk) disable iff (rstvld)
    !ready |=> !rd_vld)
    else $error("rd_vld high one cycle after ready was low");

  no_write_before_ready: assert property (@(posedge clk) disable iff (rstvld)
    !ready |-> !(a_write || b_write || cache_write || map_write))
    else $error("write strobe high before ready");

endmodule

/* sim/tb_dual_write_mem.sv */
`timescale 1ns/1ns

module tb_dual_write_mem import mem_geom_pkg::*; ();

  localparam int READY_LIMIT = 200;
  localparam int DRAIN_LIMIT = 20;
  localparam int RANDOM_CYCLES = 2000;

  logic               clk;
  logic               rstvld;
  logic               ready;
  logic               wr_a;
  logic [BITADDR-1:0] wr_a_addr;
  logic [WIDTH-1:0]   wr_a_data;
  logic               wr_b;
  logic [BITADDR-1:0] wr_b_addr;
  logic [WIDTH-1:0]   wr_b_data;
  logic               rd;
  logic [BITADDR-1:0] rd_addr;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_data;
  logic [BITPADR-1:0] rd_padr;

  // reference model of the logical contents and of the cache map.
  logic [WIDTH-1:0]   mem_m [2**BITADDR];
  logic               map_vld_m [NUMVROW];
  logic [BITVBNK-1:0] map_bnk_m [NUMVROW];

  logic [BITPADR+WIDTH-1:0] exp_q [$];
  int                       due_q [$];
  int                       cycle;
  int                       mismatches;
  int                       failures;
  logic [31:0]              lfsr;

  dual_write_mem dut_i (.*);

  bind dual_write_mem dual_write_mem_assertions assertions_i (
    .clk, .rstvld, .ready, .rd_vld,
    .a_write(pvt_a.write), .a_bank(pvt_a.bank),
    .b_write(pvt_b.write), .b_bank(pvt_b.bank),
    .cache_write, .map_write
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
  end

  // taps 32, 22, 2 and 1 give a maximal length sequence.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [BITADDR-1:0] make_addr(input int row, input int bank);
    return {BITVROW'(row), BITVBNK'(bank)};
  endfunction

  function automatic void model_write(input logic wa, input logic [BITADDR-1:0] aa,
                                      input logic [WIDTH-1:0] da, input logic wb,
                                      input logic [BITADDR-1:0] ab,
                                      input logic [WIDTH-1:0] db);
    logic               a_ok;
    logic [BITVROW-1:0] ra;
    logic [BITVROW-1:0] rb;
    ra = aa[BITADDR-1:BITVBNK];
    rb = ab[BITADDR-1:BITVBNK];
    a_ok = wa && !(wb && (aa == ab));
    if (a_ok && map_vld_m[ra] && (map_bnk_m[ra] == aa[BITVBNK-1:0])) begin
      if (wb && map_vld_m[rb] && (map_bnk_m[rb] == ab[BITVBNK-1:0])) begin
        map_vld_m[rb] = 1'b0;
      end
    end else if (a_ok && wb && (aa[BITVBNK-1:0] == ab[BITVBNK-1:0])) begin
      map_vld_m[rb] = 1'b1;
      map_bnk_m[rb] = ab[BITVBNK-1:0];
    end else if (wb && map_vld_m[rb] && (map_bnk_m[rb] == ab[BITVBNK-1:0])) begin
      map_vld_m[rb] = 1'b0;
    end
    if (a_ok) begin
      mem_m[aa] = da;
    end
    if (wb) begin
      mem_m[ab] = db;
    end
  endfunction

  // the physical address sits above the data word in the result.
  function automatic logic [BITPADR+WIDTH-1:0] expected_read(input logic [BITADDR-1:0] a);
    logic [BITVROW-1:0] row;
    logic [BITVBNK-1:0] bank;
    logic [BITPADR-1:0] padr;
    row = a[BITADDR-1:BITVBNK];
    bank = a[BITVBNK-1:0];
    if (map_vld_m[row] && (map_bnk_m[row] == bank)) begin
      padr = {CACHE_BANK, row};
    end else begin
      padr = {BITPBNK'(bank), row};
    end
    return {padr, mem_m[a]};
  endfunction

  // a read is predicted before this cycle's writes reach the model.
  task automatic drive_cycle(input logic wa, input logic [BITADDR-1:0] aa,
                             input logic [WIDTH-1:0] da, input logic wb,
                             input logic [BITADDR-1:0] ab, input logic [WIDTH-1:0] db,
                             input logic r, input logic [BITADDR-1:0] ra);
    @(negedge clk);
    wr_a = wa;
    wr_a_addr = aa;
    wr_a_data = da;
    wr_b = wb;
    wr_b_addr = ab;
    wr_b_data = db;
    rd = r;
    rd_addr = ra;
    if (r) begin
      exp_q.push_back(expected_read(ra));
      due_q.push_back(cycle + 1);
    end
    model_write(wa, aa, da, wb, ab, db);
  endtask

  task automatic read_word(input logic [BITADDR-1:0] a);
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, a);
  endtask

  task automatic write_pair(input logic [BITADDR-1:0] aa, input logic [WIDTH-1:0] da,
                            input logic [BITADDR-1:0] ab, input logic [WIDTH-1:0] db);
    drive_cycle(1'b1, aa, da, 1'b1, ab, db, 1'b0, '0);
  endtask

  task automatic run_directed();
    for (int a = 0; a < 2**BITADDR; a++) begin
      read_word(BITADDR'(a));
    end
    drive_cycle(1'b1, make_addr(2, 1), 16'h1234, 1'b0, '0, '0, 1'b1, make_addr(2, 1));
    read_word(make_addr(2, 1));
    drive_cycle(1'b0, '0, '0, 1'b1, make_addr(5, 3), 16'hbeef, 1'b1, make_addr(5, 3));
    read_word(make_addr(5, 3));
    write_pair(make_addr(1, 2), 16'ha001, make_addr(3, 2), 16'hb003);
    read_word(make_addr(3, 2));
    read_word(make_addr(1, 2));
    // row 3 of the cache holds bank 2 here, so this pair evicts it.
    write_pair(make_addr(7, 0), 16'ha007, make_addr(3, 0), 16'hb030);
    read_word(make_addr(3, 2));
    read_word(make_addr(3, 0));
    read_word(make_addr(7, 0));
    write_pair(make_addr(9, 1), 16'h0aaa, make_addr(9, 1), 16'h0bbb);
    read_word(make_addr(9, 1));
  endtask

  task automatic run_random();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      drive_cycle(1'(rand_bits(1)), BITADDR'(rand_bits(BITADDR)), WIDTH'(rand_bits(WIDTH)),
                  1'(rand_bits(1)), BITADDR'(rand_bits(BITADDR)), WIDTH'(rand_bits(WIDTH)),
                  rand_bits(2) != 0, BITADDR'(rand_bits(BITADDR)));
    end
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  always @(negedge clk) begin : compare
    logic [BITPADR+WIDTH-1:0] exp;
    if ((due_q.size() > 0) && (due_q[0] == cycle)) begin
      exp = exp_q.pop_front();
      void'(due_q.pop_front());
      assert (rd_vld) else begin
        failures++;
        $display("rd_vld did not rise one cycle after a read in cycle %0d", cycle);
      end
      assert (rd_data == exp[WIDTH-1:0]) else begin
        mismatches++;
        $display("Mismatch rd_data: got %h expected %h", rd_data, exp[WIDTH-1:0]);
      end
      assert (rd_padr == exp[BITPADR+WIDTH-1:WIDTH]) else begin
        mismatches++;
        $display("Mismatch rd_padr: got %h expected %h", rd_padr,
                 exp[BITPADR+WIDTH-1:WIDTH]);
      end
    end else begin
      assert (!rd_vld) else begin
        failures++;
        $display("rd_vld high in cycle %0d with no read outstanding", cycle);
      end
    end
  end

  initial begin : main
    int n;
    cycle = 0;
    mismatches = 0;
    failures = 0;
    lfsr = 32'h475d;
    rstvld = 1'b1;
    wr_a = 1'b0;
    wr_a_addr = '0;
    wr_a_data = '0;
    wr_b = 1'b0;
    wr_b_addr = '0;
    wr_b_data = '0;
    rd = 1'b0;
    rd_addr = '0;
    for (int a = 0; a < 2**BITADDR; a++) begin
      mem_m[a] = '0;
    end
    for (int r = 0; r < NUMVROW; r++) begin
      map_vld_m[r] = 1'b0;
      map_bnk_m[r] = '0;
    end
    repeat (10) @(negedge clk);
    assert (!ready) else begin
      failures++;
      $display("ready was high during reset");
    end
    rstvld = 1'b0;
    n = 0;
    // strobes during the init sweep must leave no trace in the memory.
    wr_a = 1'b1;
    wr_b = 1'b1;
    rd = 1'b1;
    while (!ready && (n < READY_LIMIT)) begin
      wr_a_addr = BITADDR'(rand_bits(BITADDR));
      wr_a_data = WIDTH'(rand_bits(WIDTH));
      wr_b_addr = BITADDR'(rand_bits(BITADDR));
      wr_b_data = WIDTH'(rand_bits(WIDTH));
      rd_addr = BITADDR'(rand_bits(BITADDR));
      @(negedge clk);
      n++;
    end
    wr_a = 1'b0;
    wr_b = 1'b0;
    rd = 1'b0;
    assert (ready) else begin
      failures++;
      $display("timeout while waiting for ready after reset");
    end
    if (ready) begin
      run_directed();
      run_random();
      n = 0;
      while ((due_q.size() > 0) && (n < DRAIN_LIMIT)) begin
        @(negedge clk);
        n++;
      end
      assert (due_q.size() == 0) else begin
        failures++;
        $display("timeout with %0d reads still waiting for rd_vld", due_q.size());
      end
    end
    $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/mem_geom_pkg.sv
verilog/mem_ctrl_pkg.sv
verilog/bank_wr_if.sv
verilog/init_fsm.sv
verilog/row_sweep_counter.sv
verilog/write_router.sv
verilog/pivot_banks.sv
verilog/spare_bank.sv
verilog/read_select.sv
verilog/dual_write_mem.sv
sim/dual_write_mem_assertions.sv
sim/tb_dual_write_mem.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_dual_write_mem
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx 'Finished with no errors' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
